/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = lsu_tb
FILELIST = sim.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* hdl/data_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module data_ram import lsu_pkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  wire           clk,
    input  wire addr_t    rd_addr,
    input  wire addr_t    wr_addr,
    output word_t         rd_data,
    input  wire byte_en_t wr_be,
    input  wire word_t    wr_data
);

    localparam int AW = $clog2(RAM_WORDS);

    word_t         mem [RAM_WORDS];
    logic [AW-1:0] rd_idx;
    logic [AW-1:0] wr_idx;

    assign rd_idx = rd_addr[AW+1:2];   // word index, lane bits dropped
    assign wr_idx = wr_addr[AW+1:2];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_be[i]) mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
        end
        rd_data <= mem[rd_idx];   // old word on a same-edge write
    end

    // first edge comes before reset has settled the write port
    a_wr_be_known: assert property (@(posedge clk) ##1 !$isunknown(wr_be))
        else $error("data_ram: write enable unknown");

endmodule

`default_nettype wire

/* hdl/load_align.sv */
`timescale 1ns/100ps
`default_nettype none

module load_align import lsu_pkg::*; (
    input  wire opcode_t  op,
    input  wire addr_t    addr,
    input  wire word_t    rt,
    input  wire word_t    mem_word,
    input  wire           fwd_hit,
    input  wire byte_en_t fwd_be,
    input  wire word_t    fwd_data,
    output word_t         data
);

    logic [1:0]  off;
    logic [31:0] fwd_mask;
    word_t       m;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign off = addr[1:0];

    // lanes written by the store that just committed
    assign fwd_mask = {{8{fwd_be[3]}}, {8{fwd_be[2]}}, {8{fwd_be[1]}}, {8{fwd_be[0]}}}
                    & {32{fwd_hit}};
    assign m = (mem_word & ~fwd_mask) | (fwd_data & fwd_mask);

    assign sel_byte = m[8*off +: 8];
    assign sel_half = off[1] ? m[31:16] : m[15:0];

    always_comb begin
        data = '0;
        case (op)
            OP_LW:  data = m;
            OP_LH:  data = {{16{sel_half[15]}}, sel_half};
            OP_LHU: data = {16'b0, sel_half};
            OP_LB:  data = {{24{sel_byte[7]}}, sel_byte};
            OP_LBU: data = {24'b0, sel_byte};
            OP_LWL: begin
                // memory fills from the top, rt keeps the rest
                case (off)
                    2'd0:    data = {m[7:0], rt[23:0]};
                    2'd1:    data = {m[15:0], rt[15:0]};
                    2'd2:    data = {m[23:0], rt[7:0]};
                    default: data = m;
                endcase
            end
            OP_LWR: begin
                case (off)
                    2'd0:    data = m;
                    2'd1:    data = {rt[31:24], m[31:8]};
                    2'd2:    data = {rt[31:16], m[31:16]};
                    default: data = {rt[31:8], m[31:24]};
                endcase
            end
            default: data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/lsu_csr.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_csr import lsu_pkg::*; #(
    parameter int FAULT_CNT_W = 8
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            csr_wen,
    input  wire csr_addr_t csr_addr,
    input  wire word_t     csr_wdata,
    output word_t          csr_rdata,
    input  wire            fault,
    input  wire addr_t     fault_addr,
    output logic           halt_on_fault
);

    addr_t                  bad_vaddr;
    logic                   captured;   // first fault since clear seen
    logic [FAULT_CNT_W-1:0] fault_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bad_vaddr <= '0;
            captured  <= 1'b0;
            fault_cnt <= '0;
        end else if (csr_wen && (csr_addr == CSR_COUNT)) begin
            bad_vaddr <= '0;
            captured  <= 1'b0;
            fault_cnt <= '0;
        end else if (fault) begin
            if (!captured) begin
                bad_vaddr <= fault_addr;
                captured  <= 1'b1;
            end
            if (fault_cnt != '1) fault_cnt <= fault_cnt + 1'b1;   // saturate
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halt_on_fault <= 1'b0;
        end else if (csr_wen && (csr_addr == CSR_CTRL)) begin
            halt_on_fault <= csr_wdata[0];
        end
    end

    always_comb begin
        csr_rdata = '0;
        case (csr_addr)
            CSR_BADVADDR: csr_rdata = bad_vaddr;
            CSR_COUNT:    csr_rdata[FAULT_CNT_W-1:0] = fault_cnt;
            CSR_CTRL:     csr_rdata[0] = halt_on_fault;
            default:      csr_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/lsu_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_pipe import lsu_pkg::*; #(
    parameter int CREDITS = 4
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           req_valid,
    input  wire opcode_t  req_op,
    input  wire addr_t    req_addr,
    input  wire word_t    req_wdata,
    input  wire word_t    req_rt,
    output logic          credit_ret,
    input  wire           halt_on_fault,
    output logic          fault,
    output addr_t         fault_addr,
    output opcode_t       st_op,
    output addr_t         st_addr,
    output word_t         st_wdata,
    input  wire byte_en_t st_be,
    input  wire word_t    st_word,
    input  wire           st_err,
    output addr_t         ram_rd_addr,
    output addr_t         ram_wr_addr,
    output byte_en_t      ram_wr_be,
    output word_t         ram_wr_data,
    input  wire word_t    ram_rd_data,
    output opcode_t       ld_op,
    output addr_t         ld_addr,
    output word_t         ld_rt,
    output logic          fwd_hit,
    output byte_en_t      fwd_be,
    output word_t         fwd_data,
    input  wire word_t    ld_data,
    output logic          rsp_valid,
    output logic          rsp_err,
    output word_t         rsp_data
);

    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);

    function automatic logic is_load(opcode_t op);
        return op inside {OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR};
    endfunction

    function automatic logic is_store(opcode_t op);
        return op inside {OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR};
    endfunction

    function automatic logic ld_misaligned(opcode_t op, addr_t addr);
        return ((op == OP_LW) && (addr[1:0] != 2'b00))
            || (((op == OP_LH) || (op == OP_LHU)) && addr[0]);
    endfunction

    function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] p);
        return (p == PTR_W'(CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    opcode_t          q_op    [CREDITS];
    addr_t            q_addr  [CREDITS];
    word_t            q_wdata [CREDITS];
    word_t            q_rt    [CREDITS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_cnt;
    logic             pop;
    pipe_state_t      state;

    logic     m_valid;
    opcode_t  m_op;
    addr_t    m_addr;
    word_t    m_wdata;
    word_t    m_rt;
    logic     m_fault;
    logic     m2_valid;
    opcode_t  m2_op;
    addr_t    m2_addr;
    word_t    m2_rt;
    logic     m2_st_err;
    logic     m2_fault;
    logic     w_wen;
    addr_t    w_addr;
    byte_en_t w_be;
    word_t    w_word;
    logic     c_wen;      // store written at the last edge
    addr_t    c_addr;
    byte_en_t c_be;
    word_t    c_word;
    addr_t    rsp_addr;

    assign m_fault  = m_valid && (st_err || ld_misaligned(m_op, m_addr));
    assign m2_fault = m2_valid && (m2_st_err || ld_misaligned(m2_op, m2_addr));

    // hold back anything behind a fault that will halt issue
    assign pop = (q_cnt != '0) && (state == RUN) && !(halt_on_fault && (m_fault || m2_fault));
    assign credit_ret = pop;

    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_op[wr_ptr]    <= req_op;
            q_addr[wr_ptr]  <= req_addr;
            q_wdata[wr_ptr] <= req_wdata;
            q_rt[wr_ptr]    <= req_rt;
        end
        if (pop) begin
            m_op    <= q_op[rd_ptr];
            m_addr  <= q_addr[rd_ptr];
            m_wdata <= q_wdata[rd_ptr];
            m_rt    <= q_rt[rd_ptr];
        end
        m2_op     <= m_op;
        m2_addr   <= m_addr;
        m2_rt     <= m_rt;
        m2_st_err <= st_err;
        w_addr    <= m_addr;
        w_be      <= st_be;
        w_word    <= st_word;
        c_addr    <= w_addr;
        c_be      <= w_be;
        c_word    <= w_word;
        rsp_addr  <= m2_addr;
        rsp_data  <= (m2_valid && !m2_fault && is_load(m2_op)) ? ld_data : '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_cnt     <= '0;
            m_valid   <= 1'b0;
            m2_valid  <= 1'b0;
            w_wen     <= 1'b0;
            c_wen     <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_err   <= 1'b0;
        end else begin
            if (req_valid) wr_ptr <= ptr_next(wr_ptr);
            if (pop) rd_ptr <= ptr_next(rd_ptr);
            q_cnt     <= q_cnt + CNT_W'(req_valid) - CNT_W'(pop);
            m_valid   <= pop;
            m2_valid  <= m_valid;
            w_wen     <= m_valid && !st_err && is_store(m_op);  // faulting store dropped
            c_wen     <= w_wen;
            rsp_valid <= m2_valid;
            rsp_err   <= m2_fault;
        end
    end

    // halt takes effect with the faulting response
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RUN;
        end else begin
            case (state)
                RUN:     if (m2_fault && halt_on_fault) state <= HALTED;
                HALTED:  if (!halt_on_fault) state <= RUN;
                default: state <= RUN;
            endcase
        end
    end

    assign fault      = rsp_valid && rsp_err;
    assign fault_addr = rsp_addr;

    assign st_op    = m_op;
    assign st_addr  = m_addr;
    assign st_wdata = m_wdata;

    assign ram_rd_addr = m_addr;
    assign ram_wr_addr = w_addr;
    assign ram_wr_be   = w_wen ? w_be : '0;
    assign ram_wr_data = w_word;

    assign ld_op    = m2_op;
    assign ld_addr  = m2_addr;
    assign ld_rt    = m2_rt;
    assign fwd_hit  = c_wen && (c_addr[31:2] == m2_addr[31:2]);
    assign fwd_be   = c_be;
    assign fwd_data = c_word;

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> (q_cnt != CNT_W'(CREDITS)))
        else $error("lsu_pipe: push into full request queue");

    a_wr_be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        w_wen |-> (w_be != '0))
        else $error("lsu_pipe: RAM write with no lanes");

    a_rsp_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(rsp_valid))
        else $error("lsu_pipe: rsp_valid unknown");

endmodule

`default_nettype wire

/* hdl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  byte_en_t;   // bit 0 is the low byte
    typedef logic [5:0]  opcode_t;
    typedef logic [1:0]  csr_addr_t;

    // primary opcodes, standard mips encoding
    localparam opcode_t OP_LB  = 6'b100000;
    localparam opcode_t OP_LH  = 6'b100001;
    localparam opcode_t OP_LWL = 6'b100010;
    localparam opcode_t OP_LW  = 6'b100011;
    localparam opcode_t OP_LBU = 6'b100100;
    localparam opcode_t OP_LHU = 6'b100101;
    localparam opcode_t OP_LWR = 6'b100110;
    localparam opcode_t OP_SB  = 6'b101000;
    localparam opcode_t OP_SH  = 6'b101001;
    localparam opcode_t OP_SWL = 6'b101010;
    localparam opcode_t OP_SW  = 6'b101011;
    localparam opcode_t OP_SWR = 6'b101110;

    // register block indexes
    localparam csr_addr_t CSR_BADVADDR = 2'd0;
    localparam csr_addr_t CSR_COUNT    = 2'd1;
    localparam csr_addr_t CSR_CTRL     = 2'd2;

    typedef enum logic {
        RUN,
        HALTED
    } pipe_state_t;

endpackage

`default_nettype wire

/* hdl/lsu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter int CREDITS     = 4,
    parameter int RAM_WORDS   = 256,
    parameter int FAULT_CNT_W = 8
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            req_valid,
    input  wire opcode_t   req_op,
    input  wire addr_t     req_addr,
    input  wire word_t     req_wdata,
    input  wire word_t     req_rt,
    output logic           credit_ret,
    output logic           rsp_valid,
    output word_t          rsp_data,
    output logic           rsp_err,
    input  wire            csr_wen,
    input  wire csr_addr_t csr_addr,
    input  wire word_t     csr_wdata,
    output word_t          csr_rdata
);

    logic     halt_on_fault;
    logic     fault;
    addr_t    fault_addr;
    opcode_t  st_op;
    addr_t    st_addr;
    word_t    st_wdata;
    byte_en_t st_be;
    word_t    st_word;
    logic     st_err;
    addr_t    ram_rd_addr;
    addr_t    ram_wr_addr;
    byte_en_t ram_wr_be;
    word_t    ram_wr_data;
    word_t    ram_rd_data;
    opcode_t  ld_op;
    addr_t    ld_addr;
    word_t    ld_rt;
    logic     fwd_hit;
    byte_en_t fwd_be;
    word_t    fwd_data;
    word_t    ld_data;

    lsu_pipe #(.CREDITS(CREDITS)) lsu_pipe_inst (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_rt(req_rt), .credit_ret(credit_ret),
        .halt_on_fault(halt_on_fault), .fault(fault), .fault_addr(fault_addr),
        .st_op(st_op), .st_addr(st_addr), .st_wdata(st_wdata),
        .st_be(st_be), .st_word(st_word), .st_err(st_err),
        .ram_rd_addr(ram_rd_addr), .ram_wr_addr(ram_wr_addr),
        .ram_wr_be(ram_wr_be), .ram_wr_data(ram_wr_data), .ram_rd_data(ram_rd_data),
        .ld_op(ld_op), .ld_addr(ld_addr), .ld_rt(ld_rt),
        .fwd_hit(fwd_hit), .fwd_be(fwd_be), .fwd_data(fwd_data), .ld_data(ld_data),
        .rsp_valid(rsp_valid), .rsp_err(rsp_err), .rsp_data(rsp_data)
    );

    store_format store_format_inst (
        .op(st_op), .addr(st_addr), .wdata(st_wdata),
        .be(st_be), .word(st_word), .err(st_err)
    );

    load_align load_align_inst (
        .op(ld_op), .addr(ld_addr), .rt(ld_rt), .mem_word(ram_rd_data),
        .fwd_hit(fwd_hit), .fwd_be(fwd_be), .fwd_data(fwd_data), .data(ld_data)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) data_ram_inst (
        .clk(clk), .rd_addr(ram_rd_addr), .wr_addr(ram_wr_addr),
        .rd_data(ram_rd_data), .wr_be(ram_wr_be), .wr_data(ram_wr_data)
    );

    lsu_csr #(.FAULT_CNT_W(FAULT_CNT_W)) lsu_csr_inst (
        .clk(clk), .rst_n(rst_n),
        .csr_wen(csr_wen), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata), .fault(fault), .fault_addr(fault_addr),
        .halt_on_fault(halt_on_fault)
    );

endmodule

`default_nettype wire

/* hdl/store_format.sv */
`timescale 1ns/100ps
`default_nettype none

module store_format import lsu_pkg::*; (
    input  wire opcode_t  op,
    input  wire addr_t    addr,
    input  wire word_t    wdata,
    output byte_en_t      be,
    output word_t         word,
    output logic          err
);

    logic [1:0] off;

    assign off = addr[1:0];

    always_comb begin
        be   = '0;
        word = wdata;
        case (op)
            OP_SW: begin
                if (off == 2'b00) be = 4'b1111;
            end
            OP_SH: begin
                word = {2{wdata[15:0]}};     // same half in both lanes
                if (!off[0]) be = off[1] ? 4'b1100 : 4'b0011;
            end
            OP_SB: begin
                word = {4{wdata[7:0]}};
                be   = 4'b0001 << off;
            end
            OP_SWL: begin
                case (off)
                    2'd0: begin be = 4'b0001; word = {4{wdata[31:24]}}; end
                    2'd1: begin be = 4'b0011; word = {2{wdata[31:16]}}; end
                    2'd2: begin be = 4'b0111; word = {8'b0, wdata[31:8]}; end
                    default: begin be = 4'b1111; word = wdata; end
                endcase
            end
            OP_SWR: begin
                case (off)
                    2'd0: begin be = 4'b1111; word = wdata; end
                    2'd1: begin be = 4'b1110; word = {wdata[23:0], 8'b0}; end
                    2'd2: begin be = 4'b1100; word = {2{wdata[15:0]}}; end
                    default: begin be = 4'b1000; word = {4{wdata[7:0]}}; end
                endcase
            end
            default: ;   // loads and others write nothing
        endcase
    end

    // only sw and sh have alignment rules on the store side
    assign err = ((op == OP_SW) && (off != 2'b00)) || ((op == OP_SH) && off[0]);

    always_comb begin
        if (!$isunknown(op) && !$isunknown(off)) begin
            assert (!(err && (be != '0)))
                else $error("store_format: lanes enabled on misaligned store");
        end
    end

endmodule

`default_nettype wire

/* sim.f */
hdl/lsu_pkg.sv
hdl/store_format.sv
hdl/load_align.sv
hdl/data_ram.sv
hdl/lsu_pipe.sv
hdl/lsu_csr.sv
hdl/lsu_top.sv
verif/lsu_tb.sv

/* verif/lsu_golden.mem */
// op addr wdata rt expected err ctl; ctl 0 back-to-back, 1 idle gap after, 2 held by halt
// op 3e writes register addr with wdata, op 3f reads register addr against expected
2b 00000000 11223344 00000000 00000000 0 0
2b 00000004 8899aabb 00000000 00000000 0 0
23 00000000 00000000 00000000 11223344 0 0
23 00000004 00000000 00000000 8899aabb 0 0
20 00000004 00000000 00000000 ffffffbb 0 0
20 00000005 00000000 00000000 ffffffaa 0 0
24 00000006 00000000 00000000 00000099 0 0
24 00000007 00000000 00000000 00000088 0 0
20 00000001 00000000 00000000 00000033 0 0
21 00000004 00000000 00000000 ffffaabb 0 0
25 00000006 00000000 00000000 00008899 0 0
21 00000002 00000000 00000000 00001122 0 1
2b 00000008 00000000 00000000 00000000 0 0
29 0000000a 1234cafe 00000000 00000000 0 0
28 00000009 000000a5 00000000 00000000 0 0
23 00000008 00000000 00000000 cafea500 0 0
24 0000000b 00000000 00000000 000000ca 0 0
21 0000000a 00000000 00000000 ffffcafe 0 0
20 00000009 00000000 00000000 ffffffa5 0 0
28 00000008 0000007f 00000000 00000000 0 0
20 00000008 00000000 00000000 0000007f 0 1
2b 00000010 00000000 00000000 00000000 0 0
2b 00000014 00000000 00000000 00000000 0 0
2b 00000018 00000000 00000000 00000000 0 0
2b 0000001c 00000000 00000000 00000000 0 0
2a 00000010 11223344 00000000 00000000 0 0
2a 00000015 11223344 00000000 00000000 0 0
2a 0000001a 11223344 00000000 00000000 0 0
2a 0000001f 11223344 00000000 00000000 0 0
23 00000010 00000000 00000000 00000011 0 0
23 00000014 00000000 00000000 00001122 0 0
23 00000018 00000000 00000000 00112233 0 0
23 0000001c 00000000 00000000 11223344 0 0
22 0000001c 00000000 aabbccdd 44bbccdd 0 0
22 0000001d 00000000 aabbccdd 3344ccdd 0 0
22 0000001e 00000000 aabbccdd 223344dd 0 0
22 0000001f 00000000 aabbccdd 11223344 0 0
26 0000001c 00000000 aabbccdd 11223344 0 0
26 0000001d 00000000 aabbccdd aa112233 0 0
26 0000001e 00000000 aabbccdd aabb1122 0 0
26 0000001f 00000000 aabbccdd aabbcc11 0 1
2e 00000010 55667788 00000000 00000000 0 0
2e 00000015 55667788 00000000 00000000 0 0
2e 0000001a 55667788 00000000 00000000 0 0
2e 0000001f 55667788 00000000 00000000 0 0
23 00000010 00000000 00000000 55667788 0 0
23 00000014 00000000 00000000 66778822 0 0
23 00000018 00000000 00000000 77882233 0 0
23 0000001c 00000000 00000000 88223344 0 1
2b 00000030 deadbeef 00000000 00000000 0 0
23 00000030 00000000 00000000 deadbeef 0 0
28 00000031 00000055 00000000 00000000 0 0
23 00000030 00000000 00000000 dead55ef 0 0
29 00000032 0000f00d 00000000 00000000 0 0
25 00000032 00000000 00000000 0000f00d 0 1
2b 00000005 ffffffff 00000000 00000000 1 0
29 00000009 ffffffff 00000000 00000000 1 0
23 00000002 00000000 00000000 00000000 1 0
21 00000003 00000000 00000000 00000000 1 0
25 00000005 00000000 00000000 00000000 1 0
23 00000004 00000000 00000000 8899aabb 0 0
23 00000008 00000000 00000000 cafea57f 0 1
3f 00000000 00000000 00000000 00000005 0 0
3f 00000001 00000000 00000000 00000005 0 0
3e 00000001 00000000 00000000 00000000 0 0
3f 00000001 00000000 00000000 00000000 0 0
3f 00000000 00000000 00000000 00000000 0 0
3e 00000002 00000001 00000000 00000000 0 0
3f 00000002 00000000 00000000 00000001 0 0
21 00000007 00000000 00000000 00000000 1 0
23 00000000 00000000 00000000 11223344 0 2
24 00000001 00000000 00000000 00000033 0 2
2b 00000034 01020304 00000000 00000000 0 2
3e 00000002 00000000 00000000 00000000 0 0
23 00000034 00000000 00000000 01020304 0 0
3f 00000001 00000000 00000000 00000001 0 0
3f 00000000 00000000 00000000 00000007 0 0
23 00000004 00000000 00000000 8899aabb 0 0
20 0000000b 00000000 00000000 ffffffca 0 0
26 0000001d 00000000 aabbccdd aa882233 0 0
22 0000001e 00000000 aabbccdd 223344dd 0 0

/* verif/lsu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    localparam int CREDITS      = 4;
    localparam int FIELDS       = 7;
    localparam int MAX_LINES    = 96;
    localparam int RSP_LAT      = 4;    // drive cycle to response cycle
    localparam int QUIET_CYCLES = 10;
    localparam opcode_t CSR_WR_OP = 6'h3e;
    localparam opcode_t CSR_RD_OP = 6'h3f;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    opcode_t   req_op;
    addr_t     req_addr;
    word_t     req_wdata;
    word_t     req_rt;
    logic      credit_ret;
    logic      rsp_valid;
    word_t     rsp_data;
    logic      rsp_err;
    logic      csr_wen;
    csr_addr_t csr_addr;
    word_t     csr_wdata;
    word_t     csr_rdata;

    word_t golden [FIELDS*MAX_LINES];
    word_t exp_data_q [$];
    logic  exp_err_q [$];
    logic  exp_held_q [$];   // waits behind a halt
    int    exp_cyc_q [$];
    int    cyc = 0;
    int    limit = 1000000;
    int    credits;
    int    seed;
    int    value_errs;
    int    other_errs;
    logic  halt_expect;

    lsu_top #(.CREDITS(CREDITS)) lsu_top_inst (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_rt(req_rt), .credit_ret(credit_ret),
        .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_err(rsp_err),
        .csr_wen(csr_wen), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= limit) begin
            $display("run timed out after %0d cycles, %0d responses outstanding",
                     cyc, exp_data_q.size());
            $display("errors: %0d value, %0d other", value_errs, other_errs + 1);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_response;
        word_t d;
        logic  e;
        logic  held;
        int    c;
        if (exp_data_q.size() == 0) begin
            $display("response at %0t with no request outstanding", $time);
            other_errs++;
            return;
        end
        d    = exp_data_q.pop_front();
        e    = exp_err_q.pop_front();
        held = exp_held_q.pop_front();
        c    = exp_cyc_q.pop_front();
        assert (!(held && halt_expect)) else begin
            $display("response at %0t arrived while issue should be halted", $time);
            other_errs++;
        end
        assert ((rsp_data === d) && (rsp_err === e)) else begin
            $display("FAILED %0t: got data %h err %b, expected data %h err %b",
                     $time, rsp_data, rsp_err, d, e);
            value_errs++;
        end
        if (c >= 0) begin
            assert (cyc - c == RSP_LAT) else begin
                $display("FAILED %0t: response after %0d cycles, expected %0d",
                         $time, cyc - c, RSP_LAT);
                value_errs++;
            end
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (credit_ret) credits = credits + 1;
            assert (credits <= CREDITS) else begin
                $display("credit return at %0t left more than %0d credits", $time, CREDITS);
                other_errs++;
            end
            if (rsp_valid) check_response();
        end
    end

    task automatic idle_cycle;
        @(posedge clk);
        #10 req_valid = 1'b0;
    endtask

    task automatic send_request(input opcode_t op, input addr_t addr, input word_t wdata,
                                input word_t rt, input word_t exp, input logic err,
                                input logic held);
        logic untimed;
        @(posedge clk);
        #10;
        while (credits == 0) begin
            req_valid = 1'b0;
            @(posedge clk);
            #10;
        end
        untimed = held;
        for (int i = 0; i < exp_held_q.size(); i++) begin
            if (exp_held_q[i] || (exp_cyc_q[i] < 0)) untimed = 1'b1;  // queued behind a halt
        end
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        req_rt    = rt;
        credits   = credits - 1;
        exp_data_q.push_back(exp);
        exp_err_q.push_back(err);
        exp_held_q.push_back(held);
        exp_cyc_q.push_back(untimed ? -1 : cyc);
    endtask

    // drain everything that is not parked behind a halt, then watch a while
    task automatic wait_quiet;
        idle_cycle();
        while (!((exp_data_q.size() == 0) || exp_held_q[0])) idle_cycle();
        repeat (QUIET_CYCLES) idle_cycle();
    endtask

    task automatic csr_write(input csr_addr_t a, input word_t d);
        @(posedge clk);
        #10;
        csr_wen   = 1'b1;
        csr_addr  = a;
        csr_wdata = d;
        @(posedge clk);
        #10 csr_wen = 1'b0;
        if (a == CSR_CTRL) halt_expect = d[0];
    endtask

    task automatic csr_check(input csr_addr_t a, input word_t exp);
        @(posedge clk);
        #10 csr_addr = a;
        @(negedge clk);
        assert (csr_rdata === exp) else begin
            $display("FAILED %0t: register %0d reads %h, expected %h", $time, a, csr_rdata, exp);
            value_errs++;
        end
    endtask

    initial begin
        int      n;
        int      base;
        int      gap;
        opcode_t op;
        seed        = 32'hd22f;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_op      = '0;
        req_addr    = '0;
        req_wdata   = '0;
        req_rt      = '0;
        csr_wen     = 1'b0;
        csr_addr    = '0;
        csr_wdata   = '0;
        halt_expect = 1'b0;
        credits     = CREDITS;
        value_errs  = 0;
        other_errs  = 0;
        for (int i = 0; i < FIELDS*MAX_LINES; i++) golden[i] = '1;
        $readmemh("verif/lsu_golden.mem", golden);
        n = 0;
        while ((n < MAX_LINES) && (golden[FIELDS*n] != '1)) n++;
        limit = n*8 + 200;
        repeat (4) @(posedge clk);
        #10 rst_n = 1'b1;

        for (int i = 0; i < n; i++) begin
            base = FIELDS*i;
            op   = opcode_t'(golden[base]);
            if (op == CSR_WR_OP) begin
                wait_quiet();
                csr_write(csr_addr_t'(golden[base+1]), golden[base+2]);
            end else if (op == CSR_RD_OP) begin
                wait_quiet();
                csr_check(csr_addr_t'(golden[base+1]), golden[base+4]);
            end else begin
                send_request(op, golden[base+1], golden[base+2], golden[base+3],
                             golden[base+4], golden[base+5][0], golden[base+6] == 32'd2);
                if (golden[base+6] == 32'd1) begin
                    gap = ($random(seed) & 3) + 1;
                    repeat (gap) idle_cycle();
                end
            end
        end

        idle_cycle();
        for (int k = 0; (k < 20) && (exp_data_q.size() != 0); k++) idle_cycle();
        if (exp_data_q.size() != 0) begin
            $display("%0d expected responses never arrived", exp_data_q.size());
            other_errs += exp_data_q.size();
        end
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if ((value_errs + other_errs) == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
